// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module robTb -f src.f -Mdir obj_dir
	./obj_dir/VrobTb > sim.log 2>&1 || echo "Test failed" >> sim.log
	cat sim.log
	! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== logic/reorderBuffer.sv ====
`timescale 1ns/1ps

module reorderBuffer (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 rollback,
    input  logic                 dispatchEn,
    input  robPkg::dispatchT     dispatch,
    output robPkg::robIdxT       allocIdx,
    output logic                 full,
    output logic                 empty,
    input  robPkg::robIdxT       queryIdx1,
    input  robPkg::robIdxT       queryIdx2,
    output robPkg::operandT      operand1,
    output robPkg::operandT      operand2,
    input  robPkg::cdbT          cdbAlu,
    input  robPkg::cdbT          cdbLsq,
    input  robPkg::cdbBranchT    cdbBranch,
    output robPkg::regCommitT    regCommit,
    output robPkg::storeCommitT  storeCommit,
    output robPkg::branchCommitT branchCommit
);
    import robPkg::*;

    logic     allocEn;
    logic     retire;
    robIdxT   headIdx;
    robIdxT   tailIdx;
    robEntryT headEntry;

    // decode tags the instruction with the tail slot
    assign allocIdx = tailIdx;

    robQueue u_robQueue (
        .clk        (clk),
        .arstN      (arstN),
        .rollback   (rollback),
        .dispatchEn (dispatchEn),
        .retire     (retire),
        .allocEn    (allocEn),
        .headIdx    (headIdx),
        .tailIdx    (tailIdx),
        .full       (full),
        .empty      (empty)
    );

    robEntryTable u_robEntryTable (
        .clk       (clk),
        .arstN     (arstN),
        .rollback  (rollback),
        .allocEn   (allocEn),
        .tailIdx   (tailIdx),
        .headIdx   (headIdx),
        .dispatch  (dispatch),
        .cdbAlu    (cdbAlu),
        .cdbLsq    (cdbLsq),
        .cdbBranch (cdbBranch),
        .retire    (retire),
        .queryIdx1 (queryIdx1),
        .queryIdx2 (queryIdx2),
        .operand1  (operand1),
        .operand2  (operand2),
        .headEntry (headEntry)
    );

    robCommit u_robCommit (
        .clk          (clk),
        .arstN        (arstN),
        .rollback     (rollback),
        .headEntry    (headEntry),
        .retire       (retire),
        .regCommit    (regCommit),
        .storeCommit  (storeCommit),
        .branchCommit (branchCommit),
        .headIdx      (headIdx)
    );

endmodule

// ==== logic/robCommit.sv ====
`timescale 1ns/1ps

module robCommit (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 rollback,
    input  robPkg::robEntryT     headEntry,
    output logic                 retire,
    output robPkg::regCommitT    regCommit,
    output robPkg::storeCommitT  storeCommit,
    output robPkg::branchCommitT branchCommit,
    input  robPkg::robIdxT       headIdx
);
    import robPkg::*;

    regCommitT    regNext;
    storeCommitT  storeNext;
    branchCommitT branchNext;
    logic         writesReg;
    logic         isStore;
    logic         toPredictor;

    // rollback cycle never retires
    assign retire = headEntry.valid && headEntry.ready && !rollback;

    always_comb begin
        writesReg   = 1'b0;
        isStore     = 1'b0;
        toPredictor = 1'b0;
        case (headEntry.op)
            opAlu, opLoad: writesReg = 1'b1;
            opStore:       isStore = 1'b1;
            opBranch:      toPredictor = 1'b1;
            opJump: begin
                writesReg   = 1'b1;
                toPredictor = 1'b1;
            end
            default: begin
                writesReg   = 1'b0;
                isStore     = 1'b0;
                toPredictor = 1'b0;
            end
        endcase
    end

    always_comb begin
        regNext.we      = retire && writesReg;
        regNext.destReg = headEntry.destReg;
        regNext.data    = headEntry.value;
        regNext.idx     = headIdx;

        storeNext.idx = (retire && isStore) ? headIdx : '0;

        branchNext.valid      = retire && toPredictor;
        branchNext.pc         = headEntry.pc;
        branchNext.taken      = headEntry.actTaken;
        branchNext.mispredict = headEntry.predTaken != headEntry.actTaken;
        branchNext.target     = headEntry.target;
    end

    // one-cycle pulses that receivers cannot stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regCommit    <= '0;
            storeCommit  <= '0;
            branchCommit <= '0;
        end else begin
            regCommit    <= regNext;
            storeCommit  <= storeNext;
            branchCommit <= branchNext;
        end
    end

    // every retired entry leaves at least one record
    assert property (@(posedge clk) disable iff (!arstN)
        retire |=> (regCommit.we || storeCommit.idx != '0 || branchCommit.valid));

endmodule

// ==== logic/robEntryTable.sv ====
`timescale 1ns/1ps

module robEntryTable (
    input  logic              clk,
    input  logic              arstN,
    input  logic              rollback,
    input  logic              allocEn,
    input  robPkg::robIdxT    tailIdx,
    input  robPkg::robIdxT    headIdx,
    input  robPkg::dispatchT  dispatch,
    input  robPkg::cdbT       cdbAlu,
    input  robPkg::cdbT       cdbLsq,
    input  robPkg::cdbBranchT cdbBranch,
    input  logic              retire,
    input  robPkg::robIdxT    queryIdx1,
    input  robPkg::robIdxT    queryIdx2,
    output robPkg::operandT   operand1,
    output robPkg::operandT   operand2,
    output robPkg::robEntryT  headEntry
);
    import robPkg::*;

    robEntryT entryQ [1:robEntries];
    logic     cdbIdxOk;

    // no bypass of a result landing this cycle
    function automatic operandT lookUp(robIdxT idx);
        operandT res;
        res = '0;
        if (idx != '0 && entryQ[idx].valid) begin
            res.ready = entryQ[idx].ready;
            res.data  = entryQ[idx].value;
        end
        return res;
    endfunction

    function automatic logic idxLive(robIdxT idx);
        logic res;
        res = 1'b1;
        if (idx != '0) begin
            res = entryQ[idx].valid;
        end
        return res;
    endfunction

    always_comb begin
        operand1 = lookUp(queryIdx1);
    end

    always_comb begin
        operand2 = lookUp(queryIdx2);
    end

    always_comb begin
        cdbIdxOk = idxLive(cdbAlu.idx) && idxLive(cdbLsq.idx) && idxLive(cdbBranch.idx);
    end

    assign headEntry = entryQ[headIdx];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i <= robEntries; i++) begin
                entryQ[i].valid <= 1'b0;
                entryQ[i].ready <= 1'b0;
            end
        end else if (rollback) begin
            for (int i = 1; i <= robEntries; i++) begin
                entryQ[i].valid <= 1'b0;
                entryQ[i].ready <= 1'b0;
            end
        end else begin
            if (allocEn) begin
                entryQ[tailIdx] <= '{
                    valid:     1'b1,
                    ready:     1'b0,
                    op:        dispatch.op,
                    pc:        dispatch.pc,
                    destReg:   dispatch.destReg,
                    value:     32'd0,
                    predTaken: dispatch.predTaken,
                    actTaken:  1'b0,
                    target:    32'd0
                };
            end

            // index 0 on a result bus means idle
            if (cdbAlu.idx != '0) begin
                entryQ[cdbAlu.idx].value <= cdbAlu.data;
                entryQ[cdbAlu.idx].ready <= 1'b1;
            end
            if (cdbLsq.idx != '0) begin
                entryQ[cdbLsq.idx].value <= cdbLsq.data;
                entryQ[cdbLsq.idx].ready <= 1'b1;
            end
            if (cdbBranch.idx != '0) begin
                entryQ[cdbBranch.idx].actTaken <= cdbBranch.taken;
                entryQ[cdbBranch.idx].target   <= cdbBranch.target;
                entryQ[cdbBranch.idx].value    <= cdbBranch.data;
                entryQ[cdbBranch.idx].ready    <= 1'b1;
            end

            if (retire) begin
                entryQ[headIdx].valid <= 1'b0;
                entryQ[headIdx].ready <= 1'b0;
            end
        end
    end

    // functional units only report on entries still in flight
    assert property (@(posedge clk) disable iff (!arstN)
        cdbIdxOk);

endmodule

// ==== logic/robPkg.sv ====
package robPkg;

    // index 0 is reserved for "no entry", so live indices are 1..robEntries
    localparam int robIdxW    = 4;
    localparam int robEntries = 2 ** robIdxW - 1;

    typedef logic [robIdxW-1:0] robIdxT;
    typedef logic [robIdxW-1:0] robCntT;

    typedef enum logic [2:0] {
        opAlu,
        opLoad,
        opStore,
        opBranch,
        opJump
    } robOpE;

    typedef struct packed {
        robOpE       op;
        logic [4:0]  destReg;
        logic [31:0] pc;
        logic        predTaken;
    } dispatchT;

    typedef struct packed {
        robIdxT      idx;
        logic [31:0] data;
    } cdbT;

    // branch unit result whose data is the link value of a jump
    typedef struct packed {
        robIdxT      idx;
        logic        taken;
        logic [31:0] target;
        logic [31:0] data;
    } cdbBranchT;

    typedef struct packed {
        logic        ready;
        logic [31:0] data;
    } operandT;

    typedef struct packed {
        logic        valid;
        logic        ready;
        robOpE       op;
        logic [31:0] pc;
        logic [4:0]  destReg;
        logic [31:0] value;
        logic        predTaken;
        logic        actTaken;
        logic [31:0] target;
    } robEntryT;

    typedef struct packed {
        logic        we;
        logic [4:0]  destReg;
        logic [31:0] data;
        robIdxT      idx;
    } regCommitT;

    typedef struct packed {
        robIdxT idx;
    } storeCommitT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic        mispredict;
        logic [31:0] target;
    } branchCommitT;

endpackage

// ==== logic/robQueue.sv ====
`timescale 1ns/1ps

module robQueue (
    input  logic           clk,
    input  logic           arstN,
    input  logic           rollback,
    input  logic           dispatchEn,
    input  logic           retire,
    output logic           allocEn,
    output robPkg::robIdxT headIdx,
    output robPkg::robIdxT tailIdx,
    output logic           full,
    output logic           empty
);
    import robPkg::*;

    robIdxT headQ;
    robIdxT tailQ;
    robCntT countQ;

    // circular step over 1..robEntries that never lands on 0
    function automatic robIdxT nextIdx(robIdxT idx);
        robIdxT res;
        if (idx == robIdxT'(robEntries)) begin
            res = robIdxT'(1);
        end else begin
            res = idx + robIdxT'(1);
        end
        return res;
    endfunction

    assign full    = (countQ == robCntT'(robEntries));
    assign empty   = (countQ == '0);
    assign allocEn = dispatchEn && !full;
    assign headIdx = headQ;
    assign tailIdx = tailQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headQ  <= robIdxT'(1);
            tailQ  <= robIdxT'(1);
            countQ <= '0;
        end else if (rollback) begin
            headQ  <= robIdxT'(1);
            tailQ  <= robIdxT'(1);
            countQ <= '0;
        end else begin
            if (allocEn) begin
                tailQ <= nextIdx(tailQ);
            end
            if (retire) begin
                headQ <= nextIdx(headQ);
            end
            case ({allocEn, retire})
                2'b10:   countQ <= countQ + robCntT'(1);
                2'b01:   countQ <= countQ - robCntT'(1);
                default: countQ <= countQ;
            endcase
        end
    end

    // pointers meet only when the count is at either end
    assert property (@(posedge clk) disable iff (!arstN)
        (headQ == tailQ) == (countQ == '0 || countQ == robCntT'(robEntries)));

    // commit stage must only retire something that was dispatched
    assert property (@(posedge clk) disable iff (!arstN)
        retire |-> !empty);

endmodule

// ==== sim/robTb.sv ====
`timescale 1ns/1ps

module robTb;
    import robPkg::*;

    localparam int commitWait = 40;

    logic         clk = 1'b0;
    logic         arstN;
    logic         rollback;
    logic         dispatchEn;
    dispatchT     dispatch;
    robIdxT       allocIdx;
    logic         full;
    logic         empty;
    robIdxT       queryIdx1;
    robIdxT       queryIdx2;
    operandT      operand1;
    operandT      operand2;
    cdbT          cdbAlu;
    cdbT          cdbLsq;
    cdbBranchT    cdbBranch;
    regCommitT    regCommit;
    storeCommitT  storeCommit;
    branchCommitT branchCommit;

    regCommitT    regSeen[$];
    storeCommitT  storeSeen[$];
    branchCommitT branchSeen[$];
    string        traceLines[$];
    int           errors = 0;
    int           cycles = 0;
    int           cycleLimit = 0;

    reorderBuffer u_reorderBuffer (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("timeout: run stopped after %0d cycles without finishing the trace", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // commit records are one-cycle pulses sampled mid-cycle
    always @(negedge clk) begin
        if (arstN) begin
            if (regCommit.we) begin
                regSeen.push_back(regCommit);
            end
            if (storeCommit.idx != '0) begin
                storeSeen.push_back(storeCommit);
            end
            if (branchCommit.valid) begin
                branchSeen.push_back(branchCommit);
            end
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic checkIdx(input string what, input robIdxT got, input robIdxT exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkLevel(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkOperand(input string what, input operandT got, input operandT exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkRegCommit(input regCommitT got, input regCommitT exp);
        if (got !== exp) begin
            $display("FAIL %0t: register commit %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic checkStoreCommit(input storeCommitT got, input storeCommitT exp);
        if (got !== exp) begin
            $display("FAIL %0t: store release idx %0d, expected %0d", $time, got.idx, exp.idx);
            errors++;
        end
    endtask

    task automatic checkBranchCommit(input branchCommitT got, input branchCommitT exp);
        if (got !== exp) begin
            $display("FAIL %0t: predictor update %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    function automatic int pendingCount(input logic [7:0] kind);
        int n;
        case (kind)
            "G": n = regSeen.size();
            "S": n = storeSeen.size();
            default: n = branchSeen.size();
        endcase
        return n;
    endfunction

    task automatic awaitRecord(input logic [7:0] kind, output bit arrived);
        int waited;
        waited = 0;
        while (pendingCount(kind) == 0 && waited < commitWait) begin
            nextCycle();
            waited++;
        end
        arrived = pendingCount(kind) != 0;
        if (!arrived) begin
            $display("no commit record of kind %s arrived within %0d cycles", kind, commitWait);
            errors++;
        end
    endtask

    task automatic dispatchOne(input dispatchT d, input robIdxT expIdx);
        dispatch   = d;
        dispatchEn = 1'b1;
        checkIdx("allocIdx", allocIdx, expIdx);
        nextCycle();
        dispatchEn = 1'b0;
    endtask

    initial begin
        int          fd;
        int          code;
        int          testStart;
        int          testNo;
        int          passed;
        int          failed;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] a0, a1, a2, a3, a4, a5;
        bit          arrived;
        robIdxT      expIdx;

        arstN      = 1'b0;
        rollback   = 1'b0;
        dispatchEn = 1'b0;
        dispatch   = '0;
        queryIdx1  = '0;
        queryIdx2  = '0;
        cdbAlu     = '0;
        cdbLsq     = '0;
        cdbBranch  = '0;
        testStart  = 0;
        testNo     = 0;
        passed     = 0;
        failed     = 0;

        fd = $fopen("sim/robTrace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file sim/robTrace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    traceLines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycleLimit = 20 * traceLines.size() + 200;

        repeat (10) @(posedge clk);
        #2;
        arstN = 1'b1;

        for (int n = 0; n < traceLines.size(); n++) begin
            line = traceLines[n];
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            cmd  = line.getc(0);
            code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                           a0, a1, a2, a3, a4, a5);
            case (cmd)
                "D": dispatchOne(dispatchT'{op: robOpE'(a0[2:0]), destReg: a1[4:0],
                                            pc: a2, predTaken: a3[0]}, a4[3:0]);
                "N": begin
                    // burst of ALU ops whose dest register follows the index
                    expIdx = a1[3:0];
                    for (int i = 0; i < int'(a0); i++) begin
                        dispatchOne(dispatchT'{op: opAlu, destReg: 5'(expIdx),
                                               pc: 32'h1000 + 32'(4 * i), predTaken: 1'b0}, expIdx);
                        expIdx = (expIdx == robIdxT'(robEntries)) ? robIdxT'(1)
                                                                  : expIdx + robIdxT'(1);
                    end
                end
                "A": begin
                    cdbAlu = cdbT'{idx: a0[3:0], data: a1};
                    nextCycle();
                    cdbAlu = '0;
                end
                "L": begin
                    cdbLsq = cdbT'{idx: a0[3:0], data: a1};
                    nextCycle();
                    cdbLsq = '0;
                end
                "B": begin
                    cdbBranch = cdbBranchT'{idx: a0[3:0], taken: a1[0], target: a2, data: a3};
                    nextCycle();
                    cdbBranch = '0;
                end
                "Q": begin
                    queryIdx1 = a0[3:0];
                    queryIdx2 = a1[3:0];
                    #1;
                    checkOperand("operand1", operand1, operandT'{ready: a2[0], data: a3});
                    checkOperand("operand2", operand2, operandT'{ready: a4[0], data: a5});
                end
                "R": begin
                    rollback = 1'b1;
                    nextCycle();
                    rollback = 1'b0;
                end
                "W": repeat (a0) nextCycle();
                "F": begin
                    checkLevel("full", full, a0[0]);
                    checkLevel("empty", empty, a1[0]);
                end
                "G": begin
                    awaitRecord(cmd, arrived);
                    if (arrived) begin
                        checkRegCommit(regSeen.pop_front(),
                                       regCommitT'{1'b1, a0[4:0], a1, a2[3:0]});
                    end
                end
                "S": begin
                    awaitRecord(cmd, arrived);
                    if (arrived) begin
                        checkStoreCommit(storeSeen.pop_front(), storeCommitT'{a0[3:0]});
                    end
                end
                "P": begin
                    awaitRecord(cmd, arrived);
                    if (arrived) begin
                        checkBranchCommit(branchSeen.pop_front(),
                                          branchCommitT'{1'b1, a0, a1[0], a2[0], a3});
                    end
                end
                "E": begin
                    testNo++;
                    // anything left over was never expected
                    if (regSeen.size() + storeSeen.size() + branchSeen.size() != 0) begin
                        $display("test %0d left commit records that the trace did not expect",
                                 testNo);
                        errors++;
                        regSeen.delete();
                        storeSeen.delete();
                        branchSeen.delete();
                    end
                    if (errors == testStart) begin
                        passed++;
                        $display("test %0d: ok", testNo);
                    end else begin
                        failed++;
                        $display("test %0d: %0d errors", testNo, errors - testStart);
                    end
                    testStart = errors;
                end
                default: begin
                    $display("unknown trace command %s on line %0d", cmd, n + 1);
                    errors++;
                end
            endcase
        end

        $display("tests ok %0d, tests with errors %0d, total errors %0d", passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim/robTrace.txt ====
# hex fields. D op dest pc pred allocIdx, N count firstIdx, A/L idx data, B idx taken target link
# Q idx1 idx2 rdy1 val1 rdy2 val2, R, W cycles, F full empty, G dest data idx, S idx, P pc tk mp tgt, E
N f 1
F 1 0
D 0 1f 00002000 0 1
A 1 00000011
W 1
D 0 02 00003000 0 1
G 01 00000011 1
F 1 0
R
E
D 0 05 00000100 0 1
D 1 06 00000104 0 2
Q 1 2 0 00000000 0 00000000
L 2 0000beef
Q 2 0 1 0000beef 0 00000000
A 1 00001234
G 05 00001234 1
G 06 0000beef 2
Q 1 2 0 00000000 0 00000000
E
D 2 00 00000200 0 3
D 3 00 00000204 1 4
D 4 01 00000208 1 5
L 3 00000000
B 4 0 00000300 00000000
B 5 1 00000400 0000020c
S 3
P 00000204 0 1 00000300
G 01 0000020c 5
P 00000208 1 0 00000400
E
D 0 07 00000500 0 6
D 1 08 00000504 0 7
L 7 00000088
R
F 0 1
D 0 09 00000600 0 1
A 1 00000099
G 09 00000099 1
E

// ==== src.f ====
logic/robPkg.sv
logic/robQueue.sv
logic/robEntryTable.sv
logic/robCommit.sv
logic/reorderBuffer.sv
sim/robTb.sv
